// File: hw/flit_pkg.sv
// Flit widths, header and body field layouts, flit union type
package flit_pkg;

	localparam int flit_w  = 11; // Tail flag plus one field
	localparam int field_w = 10; // Hop count or payload

	// Header view, hop count is two's complement
	typedef struct packed {
		logic                      tail;
		logic signed [field_w-1:0] hop;
	} flit_hdr_t;

	// Body view, raw payload bits
	typedef struct packed {
		logic               tail;
		logic [field_w-1:0] payload;
	} flit_body_t;

	// One 11-bit word, decoded by position in the packet
	typedef union packed {
		flit_hdr_t  hdr;
		flit_body_t body;
	} flit_t;

endpackage

// File: hw/router_pkg.sv
// Router port count, FIFO sizing, input controller state encoding
package router_pkg;

	localparam int num_ports  = 2;
	localparam int fifo_depth = 4; // Flits per input buffer
	localparam int fifo_aw    = 2; // log2 of fifo_depth

	// Input controller FSM states
	typedef enum logic [1:0] {
		idle   = 2'b00, // Waiting for a flit
		parse  = 2'b01, // Header at FIFO head
		send_0 = 2'b10, // Body flits to output 0
		send_1 = 2'b11  // Body flits to output 1
	} ctrl_state_t;

endpackage

// File: hw/flit_fifo.sv
// Input flit FIFO with valid/ready write side and empty/read pop side
`timescale 1ns/1ps

module flit_fifo (
	input  logic            clk,
	input  logic            reset,
	input  logic            wr_valid,
	input  flit_pkg::flit_t wr_data,
	output logic            wr_ready,
	input  logic            read,
	output logic            empty,
	output flit_pkg::flit_t head
);
	import flit_pkg::*;
	import router_pkg::*;

	logic [flit_w-1:0]  mem [fifo_depth];
	logic [fifo_aw-1:0] wr_ptr;
	logic [fifo_aw-1:0] rd_ptr;
	logic [fifo_aw:0]   count;
	logic               full;
	logic               push;
	logic               pop;

	assign full     = (count == (fifo_aw + 1)'(fifo_depth));
	assign empty    = (count == '0);
	assign wr_ready = ~full;
	assign push     = wr_valid & wr_ready;
	assign pop      = read & ~empty; // A stray read on empty is ignored
	assign head     = mem[rd_ptr];

	always_ff @(posedge clk) begin
		if (push)
			mem[wr_ptr] <= wr_data;
	end

	// Pointers wrap on their own, depth is a power of two
	always_ff @(posedge clk) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (push)
				wr_ptr <= wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= rd_ptr + 1'b1;
			case ({push, pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count; // Push and pop cancel out
			endcase
		end
	end

endmodule

// File: hw/input_controller.sv
// Input controller FSM: header parse, route select, hop rewrite, packet forwarding
`timescale 1ns/1ps

module input_controller (
	input  logic            clk,
	input  logic            reset,
	input  logic            empty,
	input  flit_pkg::flit_t head,
	input  logic            ready_0,
	input  logic            ready_1,
	output logic            read,
	output logic            req_0,
	output logic            req_1,
	output flit_pkg::flit_t data_out
);
	import flit_pkg::*;
	import router_pkg::*;

	ctrl_state_t               state;
	ctrl_state_t               next_state;
	logic signed [field_w-1:0] hop;
	logic                      go_up; // Header leaves on output 1

	assign hop   = head.hdr.hop;
	assign go_up = (hop > 0);

	always_ff @(posedge clk) begin
		if (reset)
			state <= idle;
		else
			state <= next_state;
	end

	always_comb begin
		next_state = state;
		read       = 1'b0;
		req_0      = 1'b0;
		req_1      = 1'b0;
		data_out   = head;

		case (state)
			idle: begin
				if (!empty)
					next_state = parse;
			end

			parse: begin
				if (empty) begin
					next_state = idle; // Tail popped and nothing behind it
				end else if (go_up) begin
					req_1            = 1'b1;
					read             = ready_1;
					data_out.hdr.hop = hop - field_w'(1); // One hop used up
					if (ready_1)
						next_state = head.hdr.tail ? parse : send_1;
				end else begin
					req_0            = 1'b1;
					read             = ready_0;
					data_out.hdr.hop = -hop;
					if (ready_0)
						next_state = head.hdr.tail ? parse : send_0;
				end
			end

			send_0: begin
				req_0 = ~empty;
				read  = ~empty & ready_0;
				// Next header, if any, is parsed right after the tail
				if (read && head.body.tail)
					next_state = parse;
			end

			send_1: begin
				req_1 = ~empty;
				read  = ~empty & ready_1;
				if (read && head.body.tail)
					next_state = parse;
			end

			default: next_state = idle;
		endcase
	end

endmodule

// File: hw/output_arbiter.sv
// Output arbiter: round-robin grant held for a whole packet, output mux
`timescale 1ns/1ps

module output_arbiter (
	input  logic            clk,
	input  logic            reset,
	input  logic            req_0,
	input  logic            req_1,
	input  logic            read_0,
	input  logic            read_1,
	input  flit_pkg::flit_t flit_0,
	input  flit_pkg::flit_t flit_1,
	input  logic            out_ready,
	output logic            ready_0,
	output logic            ready_1,
	output logic            out_valid,
	output flit_pkg::flit_t out_data
);
	import router_pkg::*;

	logic                 locked;
	logic [num_ports-1:0] lock_grant; // Held grant while locked
	logic [num_ports-1:0] grant;      // One-hot, bit i for controller i
	logic                 rr_ptr;     // High means input 1 goes first
	logic                 xfer;
	logic                 tail_xfer;

	always_comb begin
		if (locked)
			grant = lock_grant;
		else if (req_0 && req_1)
			grant = rr_ptr ? 2'b10 : 2'b01;
		else
			grant = {req_1, req_0}; // Lone request wins at once
	end

	assign ready_0   = grant[0] & out_ready;
	assign ready_1   = grant[1] & out_ready;
	assign out_valid = (grant[0] & req_0) | (grant[1] & req_1);
	assign out_data  = grant[1] ? flit_1 : flit_0;

	// A pop by the granted controller is a transfer on the output
	assign xfer      = (grant[0] & read_0) | (grant[1] & read_1);
	assign tail_xfer = xfer & out_data.body.tail;

	// Lock as soon as a flit is offered so the data holds under stall
	always_ff @(posedge clk) begin
		if (reset) begin
			locked     <= 1'b0;
			lock_grant <= '0;
			rr_ptr     <= 1'b0;
		end else if (tail_xfer) begin
			locked     <= 1'b0;
			lock_grant <= '0;
			rr_ptr     <= grant[0]; // Other input first next time
		end else if (!locked && out_valid) begin
			locked     <= 1'b1;
			lock_grant <= grant;
		end
	end

endmodule

// File: hw/router_node.sv
// Two-port wormhole router node: input FIFOs, input controllers, output arbiters
`timescale 1ns/1ps

module router_node (
	input  logic            clk,
	input  logic            reset,
	input  logic            in_valid_0,
	input  flit_pkg::flit_t in_data_0,
	output logic            in_ready_0,
	input  logic            in_valid_1,
	input  flit_pkg::flit_t in_data_1,
	output logic            in_ready_1,
	output logic            out_valid_0,
	output flit_pkg::flit_t out_data_0,
	input  logic            out_ready_0,
	output logic            out_valid_1,
	output flit_pkg::flit_t out_data_1,
	input  logic            out_ready_1
);
	import flit_pkg::*;

	flit_t head_0;
	flit_t head_1;
	flit_t flit_0;   // Controller 0 outgoing flit
	flit_t flit_1;
	logic  empty_0;
	logic  empty_1;
	logic  read_0;
	logic  read_1;
	logic  req_0_0;  // req_<input>_<output>
	logic  req_0_1;
	logic  req_1_0;
	logic  req_1_1;
	logic  rdy_0_0;  // rdy_<input>_<output>
	logic  rdy_0_1;
	logic  rdy_1_0;
	logic  rdy_1_1;

	flit_fifo fifo_0 (
		.clk(clk), .reset(reset),
		.wr_valid(in_valid_0), .wr_data(in_data_0), .wr_ready(in_ready_0),
		.read(read_0), .empty(empty_0), .head(head_0)
	);

	flit_fifo fifo_1 (
		.clk(clk), .reset(reset),
		.wr_valid(in_valid_1), .wr_data(in_data_1), .wr_ready(in_ready_1),
		.read(read_1), .empty(empty_1), .head(head_1)
	);

	input_controller ctrl_0 (
		.clk(clk), .reset(reset), .empty(empty_0), .head(head_0),
		.ready_0(rdy_0_0), .ready_1(rdy_0_1),
		.read(read_0), .req_0(req_0_0), .req_1(req_0_1), .data_out(flit_0)
	);

	input_controller ctrl_1 (
		.clk(clk), .reset(reset), .empty(empty_1), .head(head_1),
		.ready_0(rdy_1_0), .ready_1(rdy_1_1),
		.read(read_1), .req_0(req_1_0), .req_1(req_1_1), .data_out(flit_1)
	);

	// Both controllers cross into both arbiters
	output_arbiter arb_0 (
		.clk(clk), .reset(reset),
		.req_0(req_0_0), .req_1(req_1_0), .read_0(read_0), .read_1(read_1),
		.flit_0(flit_0), .flit_1(flit_1), .out_ready(out_ready_0),
		.ready_0(rdy_0_0), .ready_1(rdy_1_0),
		.out_valid(out_valid_0), .out_data(out_data_0)
	);

	output_arbiter arb_1 (
		.clk(clk), .reset(reset),
		.req_0(req_0_1), .req_1(req_1_1), .read_0(read_0), .read_1(read_1),
		.flit_0(flit_0), .flit_1(flit_1), .out_ready(out_ready_1),
		.ready_0(rdy_0_1), .ready_1(rdy_1_1),
		.out_valid(out_valid_1), .out_data(out_data_1)
	);

endmodule

// File: bench/router_node_chk.sv
// Bound assertions: grant exclusivity, idle outputs after reset, FIFO full, stall hold
`timescale 1ns/1ps

module router_node_chk (
	input logic            clk,
	input logic            reset,
	input logic            in_valid_0,
	input logic            in_ready_0,
	input logic            in_valid_1,
	input logic            in_ready_1,
	input logic            read_0,
	input logic            read_1,
	input logic            empty_0,
	input logic            empty_1,
	input logic            rdy_0_0,
	input logic            rdy_0_1,
	input logic            rdy_1_0,
	input logic            rdy_1_1,
	input logic            out_valid_0,
	input logic            out_ready_0,
	input flit_pkg::flit_t out_data_0,
	input logic            out_valid_1,
	input logic            out_ready_1,
	input flit_pkg::flit_t out_data_1
);
	import router_pkg::*;

	logic [fifo_aw:0] fill_0; // Shadow FIFO occupancy
	logic [fifo_aw:0] fill_1;

	always_ff @(posedge clk) begin
		if (reset) begin
			fill_0 <= '0;
			fill_1 <= '0;
		end else begin
			fill_0 <= fill_0 + (fifo_aw + 1)'(in_valid_0 & in_ready_0)
				- (fifo_aw + 1)'(read_0 & ~empty_0);
			fill_1 <= fill_1 + (fifo_aw + 1)'(in_valid_1 & in_ready_1)
				- (fifo_aw + 1)'(read_1 & ~empty_1);
		end
	end

	// One controller per arbiter grant
	a_grant_arb: assert property (@(posedge clk) disable iff (reset)
		!(rdy_0_0 && rdy_1_0) && !(rdy_0_1 && rdy_1_1))
		else $error("An arbiter readied both controllers at once");

	// And one arbiter per controller
	a_grant_ctrl: assert property (@(posedge clk) disable iff (reset)
		!(rdy_0_0 && rdy_0_1) && !(rdy_1_0 && rdy_1_1))
		else $error("A controller was readied by both arbiters at once");

	a_reset_idle: assert property (@(posedge clk) reset |=> !out_valid_0 && !out_valid_1)
		else $error("Output valid high after a reset edge");

	a_full_0: assert property (@(posedge clk) disable iff (reset)
		fill_0 == (fifo_aw + 1)'(fifo_depth) |-> !in_ready_0)
		else $error("Input 0 ready while its FIFO is full");

	a_full_1: assert property (@(posedge clk) disable iff (reset)
		fill_1 == (fifo_aw + 1)'(fifo_depth) |-> !in_ready_1)
		else $error("Input 1 ready while its FIFO is full");

	a_hold_0: assert property (@(posedge clk) disable iff (reset)
		out_valid_0 && !out_ready_0 |=> out_valid_0 && $stable(out_data_0))
		else $error("Output 0 dropped or changed a stalled flit");

	a_hold_1: assert property (@(posedge clk) disable iff (reset)
		out_valid_1 && !out_ready_1 |=> out_valid_1 && $stable(out_data_1))
		else $error("Output 1 dropped or changed a stalled flit");

endmodule

bind router_node router_node_chk chk (.*);

// File: bench/router_node_tb.sv
// Router node testbench: clock, reset, random packet stimulus, reference model, scoreboard
`timescale 1ns/1ps

module router_node_tb;
	import flit_pkg::*;
	import router_pkg::*;

	logic  clk = 1'b0;
	logic  reset;
	logic  in_valid_0;
	flit_t in_data_0;
	logic  in_ready_0;
	logic  in_valid_1;
	flit_t in_data_1;
	logic  in_ready_1;
	logic  out_valid_0;
	flit_t out_data_0;
	logic  out_ready_0;
	logic  out_valid_1;
	flit_t out_data_1;
	logic  out_ready_1;

	logic [flit_w-1:0] stim_q [num_ports][$];            // Flits to send, per input
	logic [flit_w-1:0] exp_q [num_ports][num_ports][$];  // By source, then output
	int                idx [num_ports];                  // Next stimulus flit per input
	logic              drv_valid [num_ports];
	logic [flit_w-1:0] drv_data [num_ports];
	logic              took [num_ports];                 // Accepted at last rising edge
	logic              in_hdr [num_ports];               // Next accepted flit is a header
	int                in_route [num_ports];
	logic              out_in_pkt [num_ports];           // Output is inside a packet
	int                out_src [num_ports];
	int                sent_count = 0;
	int                recv_count = 0;
	int                cycle_count = 0;
	int                cycle_limit;

	assign in_valid_0 = drv_valid[0];
	assign in_data_0  = drv_data[0];
	assign in_valid_1 = drv_valid[1];
	assign in_data_1  = drv_data[1];

	router_node DUT (
		.clk(clk), .reset(reset),
		.in_valid_0(in_valid_0), .in_data_0(in_data_0), .in_ready_0(in_ready_0),
		.in_valid_1(in_valid_1), .in_data_1(in_data_1), .in_ready_1(in_ready_1),
		.out_valid_0(out_valid_0), .out_data_0(out_data_0), .out_ready_0(out_ready_0),
		.out_valid_1(out_valid_1), .out_data_1(out_data_1), .out_ready_1(out_ready_1)
	);

	always #2 clk = ~clk;

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("Finished with errors");
		$fatal(1, "Run stopped at the first error");
	endtask

	task automatic check(input int got, input int expv, input string what);
		if (got != expv)
			abort_run($sformatf("Mismatch at %0t: %s, got %h expected %h",
				$time, what, got, expv));
	endtask

	// Mode 0 mixed routes, mode 1 all to output 0, mode 2 single flit
	task automatic add_packet(input int src, input int mode);
		int                len;
		int                h;
		logic [flit_w-1:0] f;
		len = (mode == 2) ? 1 : 1 + int'($urandom % 4);
		if (mode == 1)
			h = (src == 0) ? -2 * int'($urandom % 33) : -(2 * int'($urandom % 32) + 1);
		else
			h = (src == 0) ? 2 * int'($urandom % 65) - 64 : 2 * int'($urandom % 64) - 63;
		f = {len == 1, h[field_w-1:0]}; // Input 0 even hops, input 1 odd
		stim_q[src].push_back(f);
		for (int k = 1; k < len; k++) begin
			f = {k == len - 1, field_w'($urandom)};
			stim_q[src].push_back(f);
		end
	endtask

	task automatic model_input(input int src, input logic [flit_w-1:0] f);
		logic signed [field_w-1:0] hop;
		logic signed [field_w-1:0] new_hop;
		if (in_hdr[src]) begin
			hop = f[field_w-1:0];
			if (hop[field_w-1] == 1'b0 && hop != '0) begin
				in_route[src] = 1; // Above zero
				new_hop = hop - field_w'(1);
			end else begin
				in_route[src] = 0;
				new_hop = -hop;
			end
			exp_q[src][in_route[src]].push_back({f[flit_w-1], new_hop});
		end else begin
			exp_q[src][in_route[src]].push_back(f);
		end
		in_hdr[src] = f[flit_w-1]; // Header follows a tail
		sent_count++;
	endtask

	task automatic check_output(input int o, input logic [flit_w-1:0] f);
		int src;
		if (out_in_pkt[o])
			src = out_src[o];
		else
			src = int'(f[0]) ^ o; // Output 1 flips hop parity
		if (exp_q[src][o].size() == 0) begin
			abort_run($sformatf("Output %0d sent a flit at %0t with none pending from input %0d",
				o, $time, src));
		end else begin
			check(int'(f), int'(exp_q[src][o].pop_front()),
				$sformatf("output %0d flit from input %0d", o, src));
			out_in_pkt[o] = ~f[flit_w-1];
			out_src[o]    = src;
			recv_count++;
		end
	endtask

	task automatic drive_inputs();
		for (int i = 0; i < num_ports; i++) begin
			if (took[i])
				idx[i]++;
			// Valid stays up with the same data until accepted
			if (!drv_valid[i] || took[i]) begin
				if (idx[i] < stim_q[i].size() && ($urandom % 5) != 0) begin
					drv_valid[i] = 1'b1;
					drv_data[i]  = stim_q[i][idx[i]];
				end else begin
					drv_valid[i] = 1'b0;
				end
			end
		end
	endtask

	function automatic bit all_delivered();
		return idx[0] == stim_q[0].size() && idx[1] == stim_q[1].size()
			&& recv_count == sent_count;
	endfunction

	function automatic bit queues_empty();
		int n;
		n = 0;
		for (int s = 0; s < num_ports; s++)
			for (int o = 0; o < num_ports; o++)
				n += exp_q[s][o].size();
		return n == 0;
	endfunction

	// Scoreboard samples at the rising edge, inputs change on the falling edge
	always @(posedge clk) begin
		took[0] = in_valid_0 & in_ready_0 & ~reset;
		took[1] = in_valid_1 & in_ready_1 & ~reset;
		if ((reset || sent_count == 0) && (out_valid_0 || out_valid_1))
			abort_run("Output valid while reset was held or before any input was accepted");
		if (reset) begin
			for (int i = 0; i < num_ports; i++) begin
				in_hdr[i]     = 1'b1;
				in_route[i]   = 0;
				out_in_pkt[i] = 1'b0;
				out_src[i]    = 0;
			end
		end else begin
			if (took[0])
				model_input(0, in_data_0);
			if (took[1])
				model_input(1, in_data_1);
			if (out_valid_0 && out_ready_0)
				check_output(0, out_data_0);
			if (out_valid_1 && out_ready_1)
				check_output(1, out_data_1);
		end
	end

	always @(posedge clk) begin
		cycle_count++;
		if (cycle_count > cycle_limit)
			abort_run($sformatf("Timeout after %0d cycles, %0d of %0d flits delivered",
				cycle_count, recv_count, sent_count));
	end

	initial begin
		void'($urandom(32'hd4bac099));
		reset        = 1'b1;
		drv_valid[0] = 1'b0;
		drv_valid[1] = 1'b0;
		drv_data[0]  = '0;
		drv_data[1]  = '0;
		out_ready_0  = 1'b1;
		out_ready_1  = 1'b1;
		idx[0]       = 0;
		idx[1]       = 0;
		for (int p = 0; p < 30; p++) begin
			add_packet(0, 0);
			add_packet(1, 0);
		end
		for (int p = 0; p < 20; p++) begin
			add_packet(0, 1); // Both inputs contend for output 0
			add_packet(1, 1);
		end
		for (int p = 0; p < 24; p++) begin
			add_packet(0, 2);
			add_packet(1, 2);
		end
		cycle_limit = 40 * (stim_q[0].size() + stim_q[1].size());

		repeat (3) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
		while (!all_delivered()) begin
			@(negedge clk);
			drive_inputs();
			out_ready_0 = ($urandom % 10) >= 3; // Stall about 30% of cycles
			out_ready_1 = ($urandom % 10) >= 3;
		end
		out_ready_0 = 1'b1; // Both outputs open so any extra flit transfers
		out_ready_1 = 1'b1;
		repeat (10) @(negedge clk); // Catch late duplicates

		if (recv_count == sent_count && queues_empty()) begin
			$display("Finished with no errors");
			$finish;
		end else begin
			$display("Finished with errors");
			$fatal(1, "Flits left undelivered at the end of the run");
		end
	end

endmodule

// File: project.f
hw/flit_pkg.sv
hw/router_pkg.sv
hw/flit_fifo.sv
hw/input_controller.sv
hw/output_arbiter.sv
hw/router_node.sv
bench/router_node_chk.sv
bench/router_node_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build the router node testbench with Verilator and run it
set -e

cd "$(dirname "$0")"

verilator --binary --assert \
	--top-module router_node_tb \
	-f project.f \
	-o router_node_sim

./obj_dir/router_node_sim
